// File: logic/cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, rv32 encodings and i/o map for the in-order core
// modules pull these in with import cpu_pkg::* in the header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_pkg;

    localparam int xlen       = 32;                   // data and address width
    localparam int reg_addr_w = 5;                    // x0..x31
    localparam int byte_w     = 8;                    // memory bus is one byte wide

    // major opcodes of the kept subset
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    localparam logic [2:0] f3_add  = 3'b000;          // also sub
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;          // srl or sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_sb   = 3'b000;          // store funct3, byte only

    localparam logic [6:0] f7_alt = 7'b0100000;       // sub / sra(i) select

    // memory map
    localparam logic [xlen-1:0] ram_top      = 32'h0002_0000;   // last writable ram byte
    localparam logic [xlen-1:0] io_uart_addr = 32'h0003_0000;   // uart tx, 0x00 dropped
    localparam logic [xlen-1:0] io_stop_addr = 32'h0003_0004;   // any write ends the run

    // fetch fsm codes
    localparam int         fs_w     = 3;
    localparam logic [2:0] fs_issue = 3'd0;           // put first byte address out
    localparam logic [2:0] fs_wait  = 3'd1;           // ram latches the address
    localparam logic [2:0] fs_capt  = 3'd2;           // byte on mem_din, next addr out
    localparam logic [2:0] fs_out   = 3'd3;           // word handed to exec
    localparam logic [2:0] fs_hold  = 3'd4;           // until exec retires it

    // one instruction word, three rv32 layouts over the same bits
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;                                          // reg-reg
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;                                          // reg-imm, also lui upper bits
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;                                          // store
    } inst_u;

endpackage

// File: logic/inst_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-serial instruction fetch over the 8-bit ram bus
// builds one word, hands it over, waits for retirement
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module inst_fetch import cpu_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_in,       // low freezes everything
    input  logic [byte_w-1:0] mem_din,
    input  logic              inst_done,    // exec retired the word
    input  logic              halted,       // stop write seen
    output logic              rd_req,
    output logic [xlen-1:0]   rd_addr,
    output logic              inst_valid,
    output inst_u             inst
);

    logic [fs_w-1:0] state;
    logic [xlen-1:0] pc;
    logic [1:0]      idx;                   // byte being read, 0 = lsb
    logic [1:0]      rd_idx;
    logic [xlen-1:0] word_q;                // shift register, fills from the top

    // in capt the current byte is sampled and the next address goes out together
    assign rd_idx     = (state == fs_capt) ? idx + 2'd1 : idx;
    assign rd_addr    = pc + {{(xlen-2){1'b0}}, rd_idx};
    assign rd_req     = (state == fs_issue && !halted) || (state == fs_capt && idx != 2'd3);
    assign inst_valid = (state == fs_out);  // one ready cycle
    assign inst       = word_q;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state <= fs_issue;
            pc    <= '0;
            idx   <= '0;
        end
        else if (rdy_in)
        begin
            case (state)
                fs_issue: if (!halted) state <= fs_wait;     // parked for good once halted
                fs_wait:  state <= fs_capt;
                fs_capt:
                begin
                    if (idx == 2'd3)
                        state <= fs_out;
                    else
                    begin
                        idx   <= idx + 2'd1;
                        state <= fs_wait;                    // next byte already requested
                    end
                end
                fs_out:   state <= fs_hold;
                fs_hold:
                begin
                    if (inst_done)
                    begin
                        pc    <= pc + 32'd4;
                        idx   <= '0;
                        state <= fs_issue;
                    end
                end
                default:  state <= fs_issue;
            endcase
        end
    end

    // little-endian assembly, byte 0 ends up in [7:0] after four shifts
    always_ff @(posedge clk_in)
    begin
        if (rdy_in && state == fs_capt)
            word_q <= {mem_din, word_q[xlen-1:byte_w]};
    end

    a_pc_aligned: assert property (@(posedge clk_in) disable iff (rst_in)
        pc[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pc);

endmodule

// File: logic/exec_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode, register file, alu and writeback for the subset
// sb becomes a store request to the memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module exec_core import cpu_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_in,
    input  logic              inst_valid,
    input  inst_u             inst,
    input  logic              store_done,
    output logic              inst_done,
    output logic              store_req,
    output logic [xlen-1:0]   store_addr,
    output logic [byte_w-1:0] store_byte,
    output logic [xlen-1:0]   dbgreg_dout   // last value written to x1..x31
);

    logic [xlen-1:0] rf [0:(1<<reg_addr_w)-1];

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic                  alt;             // sub / sra
    logic                  is_wb;           // lui, op-imm, op
    logic                  is_sb;
    logic                  wr_en;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_s;
    logic [xlen-1:0]       op_b;
    logic [4:0]            shamt;
    logic [xlen-1:0]       sra_res;
    logic [xlen-1:0]       alu_res;
    logic [xlen-1:0]       wb_val;

    assign opcode = inst.r.opcode;          // same place in every view
    assign funct3 = inst.r.funct3;
    assign rd     = inst.r.rd;
    assign alt    = (inst.r.funct7 == f7_alt);
    assign is_wb  = (opcode == opc_lui) || (opcode == opc_op_imm) || (opcode == opc_op);
    assign is_sb  = (opcode == opc_store) && (inst.s.funct3 == f3_sb);   // sh/sw fall through
    assign wr_en  = inst_valid && is_wb && (rd != '0);                   // x0 stays zero

    assign rs1_val = rf[inst.r.rs1];
    assign rs2_val = rf[inst.r.rs2];        // s view has rs2 at the same bits

    assign imm_i = {{(xlen-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_s = {{(xlen-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

    assign op_b    = (opcode == opc_op) ? rs2_val : imm_i;
    assign shamt   = op_b[4:0];             // shamt field of i view or rs2 low bits
    assign sra_res = $unsigned($signed(rs1_val) >>> shamt);

    always_comb
    begin
        case (funct3)
            f3_add:  alu_res = (opcode == opc_op && alt) ? rs1_val - op_b : rs1_val + op_b;
            f3_sll:  alu_res = rs1_val << shamt;
            f3_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            f3_sltu: alu_res = {{(xlen-1){1'b0}}, rs1_val < op_b};
            f3_xor:  alu_res = rs1_val ^ op_b;
            f3_sr:   alu_res = alt ? sra_res : rs1_val >> shamt;
            f3_or:   alu_res = rs1_val | op_b;
            default: alu_res = rs1_val & op_b;  // f3_and
        endcase
        // lui takes the upper 20 bits straight from the word
        if (opcode == opc_lui)
            wb_val = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};
        else
            wb_val = alu_res;
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int k = 0; k < (1 << reg_addr_w); k++)
                rf[k] <= '0;
            dbgreg_dout <= '0;
            inst_done   <= 1'b0;
            store_req   <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (wr_en)
            begin
                rf[rd]      <= wb_val;
                dbgreg_dout <= wb_val;
            end
            // alu ops and unknown opcodes retire next cycle, sb waits for the bus
            inst_done <= (inst_valid && !is_sb) || (store_req && store_done);
            if (inst_valid && is_sb)
                store_req <= 1'b1;
            else if (store_done)
                store_req <= 1'b0;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && inst_valid && is_sb)
        begin
            store_addr <= rs1_val + imm_s;
            store_byte <= rs2_val[byte_w-1:0];
        end
    end

    a_done_vs_store: assert property (@(posedge clk_in) disable iff (rst_in)
        !(inst_done && store_req))
        else $error("inst_done raised while a store is still pending");

endmodule

// File: logic/mem_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// owns the byte bus: fetch reads, sb writes, uart and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_port import cpu_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_in,
    input  logic              io_buffer_full,   // uart tx cannot take a byte
    input  logic              rd_req,
    input  logic [xlen-1:0]   rd_addr,
    input  logic              store_req,
    input  logic [xlen-1:0]   store_addr,
    input  logic [byte_w-1:0] store_byte,
    output logic              store_done,       // pulse, aligned with the bus write
    output logic              halted,
    output logic [xlen-1:0]   mem_a,
    output logic [byte_w-1:0] mem_dout,
    output logic              mem_wr
);

    logic wr_q;
    logic is_uart;
    logic skip_zero;                            // 0x00 to uart completes silently
    logic wr_go;

    assign is_uart   = (store_addr == io_uart_addr);
    assign skip_zero = store_req && !store_done && is_uart && (store_byte == '0);
    assign wr_go     = store_req && !store_done && !(is_uart && (store_byte == '0))
                       && !(is_uart && io_buffer_full);     // held off while uart full
    assign mem_wr    = wr_q && rdy_in;          // a paused cycle never writes

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            wr_q       <= 1'b0;
            store_done <= 1'b0;
            halted     <= 1'b0;
            mem_a      <= '0;
        end
        else if (rdy_in)
        begin
            wr_q       <= wr_go;
            store_done <= wr_go || skip_zero;
            if (wr_go)
                mem_a <= store_addr;            // store wins over fetch
            else if (rd_req && !store_req)
                mem_a <= rd_addr;
            if (wr_q && mem_a == io_stop_addr)
                halted <= 1'b1;                 // sticky until reset
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && wr_go)
            mem_dout <= store_byte;
    end

    a_wr_range: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_wr |-> (mem_a <= ram_top || mem_a == io_uart_addr || mem_a == io_stop_addr))
        else $fatal(1, "write to invalid address %h", mem_a);

    // paused cycle: no write now and the address is still there afterwards
    a_pause_hold: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |-> !mem_wr ##1 $stable(mem_a))
        else $error("bus moved or wrote during a pause");

endmodule

// File: logic/cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order rv32 subset core, top level over the byte bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cpu import cpu_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_in,         // low pauses the core
    input  logic [byte_w-1:0] mem_din,
    input  logic              io_buffer_full,
    output logic [xlen-1:0]   mem_a,
    output logic [byte_w-1:0] mem_dout,
    output logic              mem_wr,         // 1 = write
    output logic [xlen-1:0]   dbgreg_dout
);

    logic              rd_req;
    logic [xlen-1:0]   rd_addr;
    logic              inst_valid;
    inst_u             inst;
    logic              inst_done;
    logic              store_req;
    logic [xlen-1:0]   store_addr;
    logic [byte_w-1:0] store_byte;
    logic              store_done;
    logic              halted;

    inst_fetch u_fetch (
        .clk_in, .rst_in, .rdy_in, .mem_din, .inst_done, .halted,
        .rd_req, .rd_addr, .inst_valid, .inst
    );

    exec_core u_exec (
        .clk_in, .rst_in, .rdy_in, .inst_valid, .inst, .store_done,
        .inst_done, .store_req, .store_addr, .store_byte, .dbgreg_dout
    );

    mem_port u_mem (
        .clk_in, .rst_in, .rdy_in, .io_buffer_full,
        .rd_req, .rd_addr,
        .store_req, .store_addr, .store_byte,
        .store_done, .halted,
        .mem_a, .mem_dout, .mem_wr
    );

endmodule

// File: sim/tb_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the in-order core, byte ram model
// programs are built by encoders and checked against an isa model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*;
();
    localparam int          mem_bytes = 2048;           // program and ram area
    localparam int          run_limit = 20000;          // cycles until the stop write
    localparam logic [15:0] lfsr_seed = 16'd41;

    logic              clk_in = 1'b0;
    logic              rst_in = 1'b1;
    logic              rdy_in = 1'b1;
    logic [byte_w-1:0] mem_din = '0;
    logic              io_buffer_full = 1'b0;
    logic [xlen-1:0]   mem_a;
    logic [byte_w-1:0] mem_dout;
    logic              mem_wr;
    logic [xlen-1:0]   dbgreg_dout;

    logic [7:0]  mem [0:mem_bytes-1];
    logic [31:0] prog[$];
    logic [31:0] prog_alu[$];                           // kept for the paused rerun
    logic [7:0]  exp_uart[$];
    logic [7:0]  exp_alu[$];
    logic [7:0]  uart_log[$];
    logic [31:0] regs [0:31];                           // isa reference model
    logic [31:0] last_wr;
    logic [31:0] last_alu;
    logic [31:0] exp_ram_a;
    logic [7:0]  exp_ram_b;
    int          ram_cnt;
    logic [31:0] ram_a;
    logic [7:0]  ram_b;
    logic        stop_seen = 1'b0;
    logic        rdy_rand = 1'b0;
    logic        full_rand = 1'b0;
    logic        hold_full = 1'b0;
    logic [15:0] lfsr = lfsr_seed;

    cpu dut (.*);

    always #4 clk_in = ~clk_in;

    task automatic die(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 16'hB400;                     // galois taps 16,14,13,11
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    // ram model, byte comes back one edge after the address
    always @(posedge clk_in)
    begin
        mem_din        <= #1 (mem_a < mem_bytes) ? mem[mem_a[10:0]] : 8'h00;
        rdy_in         <= #1 rdy_rand ? next_bit() : 1'b1;
        io_buffer_full <= #1 full_rand ? next_bit() : hold_full;
        if (!rst_in)
        begin
            assert (!(mem_wr && !rdy_in)) else die("mem_wr was high while rdy_in was low");
            if (mem_wr)
            begin
                if (mem_a == io_uart_addr)
                    uart_log.push_back(mem_dout);
                else if (mem_a == io_stop_addr)
                    stop_seen = 1'b1;
                else
                begin
                    if (mem_a < mem_bytes)
                        mem[mem_a[10:0]] = mem_dout;
                    ram_cnt++;
                    ram_a = mem_a;
                    ram_b = mem_dout;
                end
            end
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // rv32 alu rules, alt selects sub or sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 0)
        begin
            regs[rd] = v;
            last_wr  = v;
        end
    endtask

    task automatic model_clear();
        foreach (regs[k])
            regs[k] = '0;
        last_wr = '0;
        prog.delete();
        exp_uart.delete();
    endtask

    task automatic put_lui(input logic [4:0] rd, input logic [19:0] imm20);
        prog.push_back({imm20, rd, opc_lui});
        write_reg(rd, {imm20, 12'b0});
    endtask

    task automatic put_i(input logic [2:0] f3, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, f3, rd, opc_op_imm});
        write_reg(rd, alu_ref(f3, f3 == 3'd5 && imm[10], regs[rs1], sext12(imm)));
    endtask

    task automatic put_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opc_op});
        write_reg(rd, alu_ref(f3, alt, regs[rs1], regs[rs2]));
    endtask

    task automatic put_sb(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        logic [7:0]  b;
        addr = regs[rs1] + sext12(imm);
        b    = regs[rs2][7:0];
        prog.push_back({imm[11:5], rs2, rs1, 3'b000, imm[4:0], opc_store});
        if (addr == io_uart_addr && b != 8'h00)
            exp_uart.push_back(b);                      // zero bytes never reach the bus
        else if (addr != io_uart_addr && addr != io_stop_addr)
        begin
            exp_ram_a = addr;
            exp_ram_b = b;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        #1 rst_in = 1'b1;
        repeat (3) @(posedge clk_in);
        #1 rst_in = 1'b0;
    endtask

    // load, run to the stop write, then check uart log, dbgreg and a quiet bus
    task automatic run_prog(input int full_cycles);
        int          cnt;
        logic [31:0] a_q;
        foreach (mem[k])
            mem[k] = 8'(k ^ (k >> 8));
        foreach (prog[k])
            for (int b = 0; b < 4; b++)
                mem[4*k+b] = prog[k][8*b +: 8];
        uart_log.delete();
        ram_cnt   = 0;
        stop_seen = 1'b0;
        hold_full = (full_cycles > 0);
        apply_reset();
        if (full_cycles > 0)
        begin
            repeat (full_cycles) @(negedge clk_in);
            assert (uart_log.size() == 0) else die("uart was written while io_buffer_full was high");
            hold_full = 1'b0;
        end
        cnt = 0;
        while (!stop_seen)
        begin
            @(negedge clk_in);
            cnt++;
            if (cnt > run_limit)
                die("timed out waiting for the write to the stop address");
        end
        assert (uart_log.size() == exp_uart.size())
            else die($sformatf("Fail uart_log.size expected %h got %h",
                               exp_uart.size(), uart_log.size()));
        foreach (exp_uart[k])
            assert (uart_log[k] == exp_uart[k])
                else die($sformatf("Fail uart_log[%0d] expected %h got %h",
                                   k, exp_uart[k], uart_log[k]));
        assert (dbgreg_dout == last_wr)
            else die($sformatf("Fail dbgreg_dout expected %h got %h", last_wr, dbgreg_dout));
        a_q = mem_a;
        repeat (50)
        begin
            @(negedge clk_in);
            assert (mem_a == a_q)
                else die($sformatf("Fail mem_a expected %h got %h", a_q, mem_a));
            assert (!mem_wr) else die("mem_wr went high after the stop write");
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        @(negedge clk_in);
        assert (!mem_wr) else die("mem_wr high right after reset");
        assert (dbgreg_dout == 0)
            else die($sformatf("Fail dbgreg_dout expected %h got %h", 32'h0, dbgreg_dout));
        @(negedge clk_in);
        assert (mem_a == 0)
            else die($sformatf("Fail mem_a expected %h got %h", 32'h0, mem_a));
    endtask

    task automatic test_alu_ops();
        logic [4:0]  rd;
        logic [11:0] imm;
        model_clear();
        put_lui(31, 20'h00030);                         // x31 = uart base
        put_i(3'd0, 1, 0, 12'(rand_bits(12)));
        put_i(3'd0, 2, 0, 12'(rand_bits(12)));
        put_lui(3, 20'(rand_bits(20)));
        rd = 4;
        for (int k = 0; k < 8; k++)
            for (int alt = 0; alt < 2; alt++)
                if (alt == 0 || k == 5)
                begin
                    imm = (k == 1 || k == 5) ? {alt ? 7'h20 : 7'h00, 5'(rand_bits(5))}
                                             : 12'(rand_bits(12));
                    put_i(3'(k), rd, rd[0] ? 5'd1 : 5'd3, imm);
                    put_sb(rd, 31, 0);
                    rd++;
                end
        for (int k = 0; k < 8; k++)
            for (int alt = 0; alt < 2; alt++)
                if (alt == 0 || k == 0 || k == 5)
                begin
                    put_r(3'(k), 1'(alt), rd, rd[0] ? 5'd1 : 5'd3, 2);
                    put_sb(rd, 31, 0);
                    rd++;
                end
        put_i(3'd0, 0, 1, 12'h005);                     // x0 stays zero
        put_sb(0, 31, 0);
        put_sb(0, 31, 4);
        prog_alu = prog;
        exp_alu  = exp_uart;
        last_alu = last_wr;
        run_prog(0);
    endtask

    task automatic test_ram_store();
        model_clear();
        put_lui(31, 20'h00030);
        put_i(3'd0, 5, 0, 12'(rand_bits(12)));
        put_i(3'd0, 6, 0, {3'b010, 9'(rand_bits(9))}); // 0x400..0x5ff
        put_sb(5, 6, {8'h00, 4'(rand_bits(4))});
        put_sb(0, 31, 4);
        run_prog(0);
        assert (ram_cnt == 1) else die("expected exactly one ram write");
        assert (ram_a == exp_ram_a)
            else die($sformatf("Fail mem_a expected %h got %h", exp_ram_a, ram_a));
        assert (ram_b == exp_ram_b)
            else die($sformatf("Fail mem_dout expected %h got %h", exp_ram_b, ram_b));
    endtask

    task automatic test_paused_bus();
        prog      = prog_alu;
        exp_uart  = exp_alu;
        last_wr   = last_alu;
        rdy_rand  = 1'b1;
        full_rand = 1'b1;                               // uart stalls as well
        run_prog(0);
        rdy_rand  = 1'b0;
        full_rand = 1'b0;
    endtask

    task automatic test_uart_full();
        model_clear();
        put_lui(31, 20'h00030);
        put_i(3'd0, 7, 0, 12'h041);
        put_i(3'd0, 8, 0, 12'h042);
        put_sb(7, 31, 0);
        put_sb(8, 31, 0);
        put_sb(0, 31, 4);
        run_prog(300);
    endtask

    initial
    begin
        test_reset_state();
        test_alu_ops();
        test_ram_store();
        test_paused_bus();
        test_uart_full();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: compile.f
logic/cpu_pkg.sv
logic/inst_fetch.sv
logic/exec_core.sv
logic/mem_port.sv
logic/cpu.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu -f compile.f -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim \
    || exit 1
